//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_mem_top
FILELIST = vlog.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /Simulation PASSED/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- design/avalon_burst.sv
//--------------------
// Avalon-MM burst master for the read and write links.
// Picks one pending burst, write first, and runs it on the 32-bit
// bus. Read words are stored by beat into burst_rdata, which holds
// until the next read burst starts. done pulses one cycle after the
// last beat.
//--------------------

`timescale 1ns/1ps

module avalon_burst
    import mem_pkg::*;
#(
    parameter int MAX_DWORDS = MAX_READ_DWORDS
) (
    input  logic               clk,
    input  logic               rst,

    mem_link_if.responder      rd,
    mem_link_if.responder      wr,
    output burst_rdata_t       burst_rdata,

    output logic [ADDR_W-1:2]  avm_address,
    output dword_t             avm_writedata,
    output logic [3:0]         avm_byteenable,
    output logic [3:0]         avm_burstcount,
    output logic               avm_write,
    output logic               avm_read,

    input  logic               avm_waitrequest,
    input  logic               avm_readdatavalid,
    input  dword_t             avm_readdata
);

    typedef enum logic [1:0] {S_IDLE, S_WRITE, S_RCMD, S_RCOLLECT} state_t;

    state_t       state;
    logic [1:0]   beat;             // beats done so far
    logic         rd_done_q;
    logic         wr_done_q;
    burst_rdata_t rdata_q;

    logic         start_wr;
    logic         start_rd;
    logic         last_beat;

    // a link still shows go in its done cycle, so skip it then
    assign start_wr  = (state == S_IDLE) && wr.go && !wr_done_q;
    assign start_rd  = (state == S_IDLE) && rd.go && !rd_done_q && !start_wr;
    assign last_beat = ({2'b00, beat} == avm_burstcount - 4'd1);

    //--------------------
    // burst FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            avm_write <= 1'b0;
            avm_read  <= 1'b0;
            rd_done_q <= 1'b0;
            wr_done_q <= 1'b0;
        end else begin
            rd_done_q <= 1'b0;
            wr_done_q <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_wr) begin
                        avm_write <= 1'b1;
                        state     <= S_WRITE;
                    end else if (start_rd) begin
                        avm_read <= 1'b1;
                        state    <= S_RCMD;
                    end
                end
                S_WRITE: begin
                    if (!avm_waitrequest && last_beat) begin
                        avm_write <= 1'b0;
                        wr_done_q <= 1'b1;
                        state     <= S_IDLE;
                    end
                end
                S_RCMD: begin
                    if (!avm_waitrequest) begin   // one command per burst
                        avm_read <= 1'b0;
                        state    <= S_RCOLLECT;
                    end
                end
                default: begin
                    if (avm_readdatavalid && last_beat) begin
                        rd_done_q <= 1'b1;
                        state     <= S_IDLE;
                    end
                end
            endcase
        end
    end

    //--------------------
    // command payload and beat data
    always_ff @(posedge clk) begin
        if (start_wr) begin
            avm_address    <= wr.req.address[ADDR_W-1:2];
            avm_burstcount <= {2'b00, wr.req.dword_length};
            avm_writedata  <= wr.req.data[DWORD_W-1:0];
            avm_byteenable <= wr.req.byteenable_0;
            beat           <= 2'd0;
        end else if (start_rd) begin
            avm_address    <= rd.req.address[ADDR_W-1:2];
            avm_burstcount <= {2'b00, rd.req.dword_length};
            avm_byteenable <= 4'hF;
            beat           <= 2'd0;
        end else if (state == S_WRITE && !avm_waitrequest) begin
            avm_writedata  <= {8'h00, wr.req.data[55:32]};  // upper dword
            avm_byteenable <= wr.req.byteenable_1;
            beat           <= beat + 2'd1;
        end else if (state == S_RCOLLECT && avm_readdatavalid) begin
            rdata_q[beat*DWORD_W +: DWORD_W] <= avm_readdata;
            beat                             <= beat + 2'd1;
        end
    end

    assign rd.done     = rd_done_q;
    assign wr.done     = wr_done_q;
    assign burst_rdata = rdata_q;

    a_burstcount: assert property (
        @(posedge clk) disable iff (rst)
        (avm_read || avm_write) |->
            (avm_burstcount >= 4'd1 && avm_burstcount <= 4'(MAX_DWORDS))
    );

    a_one_command: assert property (
        @(posedge clk) disable iff (rst)
        !(avm_read && avm_write)
    );

endmodule

//--- design/link_stage.sv
//--------------------
// One-slot register stage on a burst link.
// Takes the upstream request into a register and presents it
// downstream on the next cycle; done passes straight back.
// Used for both read and write bursts through REQ_T.
//--------------------

`timescale 1ns/1ps

module link_stage #(
    parameter type REQ_T = logic
) (
    input  logic          clk,
    input  logic          rst,

    mem_link_if.responder up,
    mem_link_if.requester dn
);

    logic busy;     // slot holds a request
    REQ_T req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (!busy && up.go) begin
            busy <= 1'b1;
        end else if (busy && dn.done) begin
            busy <= 1'b0;           // idle in the cycle after done
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && up.go) begin
            req_q <= up.req;
        end
    end

    assign dn.go   = busy;
    assign dn.req  = req_q;
    assign up.done = dn.done;       // same-cycle completion upstream

    //--------------------
    // the bus master reads req over several cycles of one burst
    a_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        (dn.go && !dn.done) |=> $stable(dn.req)
    );

endmodule

//--- design/mem_link_if.sv
//--------------------
// Request link with the do/done handshake.
// The requester raises go with req valid and holds both until the
// one-cycle done pulse; go drops in the cycle after done.
// REQ_T selects the burst request payload.
//--------------------

`timescale 1ns/1ps

interface mem_link_if #(
    parameter type REQ_T = logic
) ();

    logic go;       // request strobe, held until done
    logic done;     // one-cycle completion pulse
    REQ_T req;      // payload, stable while go is high

    modport requester (
        output go,
        output req,
        input  done
    );

    modport responder (
        input  go,
        input  req,
        output done
    );

endinterface

//--- design/mem_pkg.sv
//--------------------
// Shared widths and burst request types for the data-memory path.
// Every RTL block that touches an address, a bus word or a burst
// request takes its definitions from here by wildcard import.
//--------------------

package mem_pkg;

    //--------------------
    // bus geometry
    localparam int ADDR_W          = 32;
    localparam int DWORD_W         = 32;
    localparam int MAX_READ_DWORDS = 3;   // 8 bytes at offset 3 touch 3 dwords

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DWORD_W-1:0] dword_t;

    //--------------------
    // CPU side lengths and data
    typedef logic [3:0]  read_len_t;      // 1..8 bytes
    typedef logic [2:0]  write_len_t;     // 1..4 bytes
    typedef logic [1:0]  dword_len_t;     // 1..3 dwords
    typedef logic [63:0] read_data_t;

    // dword 0 of the burst sits in the low bits
    typedef logic [MAX_READ_DWORDS*DWORD_W-1:0] burst_rdata_t;

    //--------------------
    // burst requests
    typedef struct packed {
        addr_t      address;        // dword aligned
        dword_len_t dword_length;
    } readburst_req_t;

    typedef struct packed {
        addr_t      address;        // dword aligned
        dword_len_t dword_length;   // 1 or 2
        logic [3:0] byteenable_0;
        logic [3:0] byteenable_1;
        logic [55:0] data;          // write data shifted by the byte offset
    } writeburst_req_t;

endpackage

//--- design/mem_read.sv
//--------------------
// CPU read port. Turns a 1..8 byte read at any byte address into a
// dword read burst, then aligns the returned bytes so the first
// requested byte lands in bits 7:0, with zeros above the length.
//--------------------

`timescale 1ns/1ps

module mem_read
    import mem_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  logic          read_do,
    input  addr_t         read_address,
    input  read_len_t     read_length,
    output logic          read_done,
    output read_data_t    read_data,

    mem_link_if.requester burst,
    input  burst_rdata_t  burst_rdata
);

    typedef enum logic [1:0] {S_IDLE, S_BURST, S_DONE} state_t;

    state_t         state;
    logic [1:0]     off_q;          // byte offset in first dword
    read_len_t      len_q;
    readburst_req_t req_q;

    logic [3:0]     span;
    logic [3:0]     span_up;
    dword_len_t     dwords;
    burst_rdata_t   shifted;
    read_data_t     aligned;

    assign span    = {2'b00, read_address[1:0]} + read_length;
    assign span_up = span + 4'd3;   // round up to whole dwords
    assign dwords  = span_up[3:2];

    always_comb begin
        shifted = burst_rdata >> {off_q, 3'b000};
        for (int i = 0; i < 8; i++) begin
            aligned[i*8 +: 8] = (i < len_q) ? shifted[i*8 +: 8] : 8'h00;
        end
    end

    //--------------------
    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            read_done <= 1'b0;
        end else begin
            read_done <= 1'b0;
            case (state)
                S_IDLE:  if (read_do) state <= S_BURST;
                S_BURST: if (burst.done) begin
                    read_done <= 1'b1;
                    state     <= S_DONE;
                end
                default: state <= S_IDLE;   // CPU drops read_do in S_DONE
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && read_do) begin
            off_q              <= read_address[1:0];
            len_q              <= read_length;
            req_q.address      <= {read_address[ADDR_W-1:2], 2'b00};
            req_q.dword_length <= dwords;
        end
        if (state == S_BURST && burst.done) begin
            read_data <= aligned;   // burst_rdata valid from done on
        end
    end

    assign burst.go  = (state == S_BURST);
    assign burst.req = req_q;

    a_read_length: assert property (
        @(posedge clk) disable iff (rst)
        read_do |-> (read_length >= 4'd1 && read_length <= 4'd8)
    );

endmodule

//--- design/mem_top.sv
//--------------------
// Data-memory path top level. CPU read and write ports feed their
// burst builders, each through a one-slot link stage, into one
// Avalon-MM burst master on a 32-bit bus.
//--------------------

`timescale 1ns/1ps

module mem_top
    import mem_pkg::*;
#(
    parameter int MAX_DWORDS = MAX_READ_DWORDS
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               read_do,
    input  addr_t              read_address,
    input  read_len_t          read_length,
    output logic               read_done,
    output read_data_t         read_data,

    input  logic               write_do,
    input  addr_t              write_address,
    input  write_len_t         write_length,
    input  dword_t             write_data,
    output logic               write_done,

    output logic [ADDR_W-1:2]  avm_address,
    output dword_t             avm_writedata,
    output logic [3:0]         avm_byteenable,
    output logic [3:0]         avm_burstcount,
    output logic               avm_write,
    output logic               avm_read,
    input  logic               avm_waitrequest,
    input  logic               avm_readdatavalid,
    input  dword_t             avm_readdata
);

    mem_link_if #(.REQ_T(readburst_req_t))  rd_link ();
    mem_link_if #(.REQ_T(readburst_req_t))  rd_bus ();
    mem_link_if #(.REQ_T(writeburst_req_t)) wr_link ();
    mem_link_if #(.REQ_T(writeburst_req_t)) wr_bus ();

    burst_rdata_t burst_rdata;

    //--------------------
    // read path
    mem_read u_mem_read (
        .clk          (clk),
        .rst          (rst),
        .read_do      (read_do),
        .read_address (read_address),
        .read_length  (read_length),
        .read_done    (read_done),
        .read_data    (read_data),
        .burst        (rd_link.requester),
        .burst_rdata  (burst_rdata)
    );

    link_stage #(.REQ_T(readburst_req_t)) u_rd_stage (
        .clk (clk),
        .rst (rst),
        .up  (rd_link.responder),
        .dn  (rd_bus.requester)
    );

    //--------------------
    // write path
    mem_write u_mem_write (
        .clk           (clk),
        .rst           (rst),
        .write_do      (write_do),
        .write_address (write_address),
        .write_length  (write_length),
        .write_data    (write_data),
        .write_done    (write_done),
        .burst         (wr_link.requester)
    );

    link_stage #(.REQ_T(writeburst_req_t)) u_wr_stage (
        .clk (clk),
        .rst (rst),
        .up  (wr_link.responder),
        .dn  (wr_bus.requester)
    );

    //--------------------
    // bus master
    avalon_burst #(.MAX_DWORDS(MAX_DWORDS)) u_avalon_burst (
        .clk               (clk),
        .rst               (rst),
        .rd                (rd_bus.responder),
        .wr                (wr_bus.responder),
        .burst_rdata       (burst_rdata),
        .avm_address       (avm_address),
        .avm_writedata     (avm_writedata),
        .avm_byteenable    (avm_byteenable),
        .avm_burstcount    (avm_burstcount),
        .avm_write         (avm_write),
        .avm_read          (avm_read),
        .avm_waitrequest   (avm_waitrequest),
        .avm_readdatavalid (avm_readdatavalid),
        .avm_readdata      (avm_readdata)
    );

endmodule

//--- design/mem_write.sv
//--------------------
// CPU write port. Turns a 1..4 byte write at any byte address into a
// write burst of one dword, or two when the bytes cross a dword edge.
// Byte enables and data are shifted up by the byte offset.
//--------------------

`timescale 1ns/1ps

module mem_write
    import mem_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  logic          write_do,
    input  addr_t         write_address,
    input  write_len_t    write_length,
    input  dword_t        write_data,
    output logic          write_done,

    mem_link_if.requester burst
);

    typedef enum logic [1:0] {S_IDLE, S_BURST, S_DONE} state_t;

    state_t          state;
    writeburst_req_t req_q;

    logic [7:0]      be_len;        // one bit per written byte
    logic [7:0]      be_all;
    logic [55:0]     data_shifted;

    assign be_len       = (8'h01 << write_length) - 8'h01;
    assign be_all       = be_len << write_address[1:0];
    assign data_shifted = {24'h000000, write_data} << {write_address[1:0], 3'b000};

    //--------------------
    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            write_done <= 1'b0;
        end else begin
            write_done <= 1'b0;
            case (state)
                S_IDLE:  if (write_do) state <= S_BURST;
                S_BURST: if (burst.done) begin
                    write_done <= 1'b1;
                    state      <= S_DONE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && write_do) begin
            req_q.address      <= {write_address[ADDR_W-1:2], 2'b00};
            req_q.byteenable_0 <= be_all[3:0];
            req_q.byteenable_1 <= be_all[7:4];      // spill into next dword
            req_q.dword_length <= (be_all[7:4] != 4'h0) ? 2'd2 : 2'd1;
            req_q.data         <= data_shifted;
        end
    end

    assign burst.go  = (state == S_BURST);
    assign burst.req = req_q;

endmodule

//--- test/tb_clock.sv
//--------------------
// Clock and reset for the testbench.
// clk toggles every half period; rst stays high for the first
// RESET_CYCLES rising edges and drops on a falling edge.
//--------------------

`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;             // released away from the active edge
    end

endmodule

//--- test/tb_mem_top.sv
//--------------------
// Testbench for the data-memory path. Random CPU writes and reads
// run against an Avalon slave memory with random waitrequest and
// read latency; a byte-array reference model gives the expected data.
// Inputs change on the falling edge and the bus is sampled on the rising one.
//--------------------

`timescale 1ns/1ps

module tb_mem_top
    import mem_pkg::*;
();

    localparam int N_WRITES  = 80;
    localparam int N_READS   = 80;
    localparam int N_PAIRS   = 10;
    localparam int N_TRANS   = N_WRITES + N_READS + 2 * N_PAIRS;
    localparam int MEM_BYTES = 4096;

    logic clk;
    logic rst;
    logic read_do, write_do, read_done, write_done;
    addr_t read_address, write_address;
    read_len_t read_length;
    write_len_t write_length;
    dword_t write_data, avm_writedata, avm_readdata;
    read_data_t read_data;
    logic [ADDR_W-1:2] avm_address;
    logic [3:0] avm_byteenable, avm_burstcount;
    logic avm_write, avm_read, avm_waitrequest, avm_readdatavalid;

    logic [7:0] slave_mem [MEM_BYTES];
    logic [7:0] ref_mem [MEM_BYTES];

    // expected bus commands for the current request
    logic [ADDR_W-1:2] exp_wr_addr, exp_rd_addr;
    dword_len_t exp_wr_count, exp_rd_count;
    logic [3:0] exp_be [2];
    dword_t exp_wdata [2];
    bit cmd_log [$];                // burst kinds in bus order (1 is write)

    // bus snapshot taken on the rising edge
    logic held, acc_w, acc_r, s_w, s_r;
    logic [ADDR_W-1:2] s_addr;
    dword_t s_wdata;
    logic [3:0] s_be, s_bc;

    // slave read response state
    int wbeat;
    logic rd_pending;
    logic [ADDR_W-1:2] rd_addr;
    int rd_left, rd_delay;

    tb_clock #(.PERIOD(8), .RESET_CYCLES(4)) u_tb_clock (.clk(clk), .rst(rst));

    mem_top u_mem_top (.*);

    //--------------------
    // reporting
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input dword_t exp, input dword_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR at %0t: %s expected %h, actual %h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input dword_len_t exp, input dword_len_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR at %0t: %s expected %0d, actual %0d",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_read_data(input string name, input read_data_t exp,
                                   input read_data_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR at %0t: %s expected %h, actual %h",
                                     $time, name, exp, act));
        end
    endtask

    //--------------------
    // memory helpers
    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a) ^ {4'(a >> 8), 4'(a >> 8)};     // all 12 address bits
    endfunction

    function automatic dword_t slave_word(input int base);
        return {slave_mem[base+3], slave_mem[base+2], slave_mem[base+1], slave_mem[base]};
    endfunction

    function automatic dword_t ref_word(input int base);
        return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
    endfunction

    //--------------------
    // Avalon slave model
    always @(posedge clk) begin
        held    = !rst && (avm_read || avm_write) && avm_waitrequest;
        acc_w   = !rst && avm_write && !avm_waitrequest;
        acc_r   = !rst && avm_read && !avm_waitrequest;
        s_w     = avm_write;
        s_r     = avm_read;
        s_addr  = avm_address;
        s_wdata = avm_writedata;
        s_be    = avm_byteenable;
        s_bc    = avm_burstcount;
    end

    task automatic accept_write_beat();
        int base;
        dword_t mask;
        base = int'(s_addr[11:2]) * 4 + wbeat * 4;
        if (wbeat == 0) cmd_log.push_back(1'b1);
        check_word("avm_address", dword_t'(exp_wr_addr), dword_t'(s_addr));
        check_count("avm_burstcount", exp_wr_count, dword_len_t'(s_bc));
        check_word("avm_byteenable", dword_t'(exp_be[wbeat]), dword_t'(s_be));
        for (int i = 0; i < 4; i++) begin
            mask[i*8 +: 8] = {8{s_be[i]}};
        end
        check_word("avm_writedata", exp_wdata[wbeat] & mask, s_wdata & mask);
        for (int i = 0; i < 4; i++) begin
            if (s_be[i]) slave_mem[(base + i) % MEM_BYTES] = s_wdata[i*8 +: 8];
        end
        wbeat++;
        if (wbeat >= int'(s_bc)) wbeat = 0;
    endtask

    task automatic accept_read_cmd();
        cmd_log.push_back(1'b0);
        check_word("avm_address", dword_t'(exp_rd_addr), dword_t'(s_addr));
        check_count("avm_burstcount", exp_rd_count, dword_len_t'(s_bc));
        rd_pending = 1'b1;
        rd_addr    = s_addr;
        rd_left    = int'(s_bc);
        rd_delay   = int'($urandom_range(3, 0));
    endtask

    always @(negedge clk) begin
        if (held) begin                         // outputs must not move under wait
            check_word("avm_address", dword_t'(s_addr), dword_t'(avm_address));
            check_word("avm_writedata", s_wdata, avm_writedata);
            check_word("avm_byteenable", dword_t'(s_be), dword_t'(avm_byteenable));
            check_word("avm_burstcount", dword_t'(s_bc), dword_t'(avm_burstcount));
            check_word("avm_write", dword_t'(s_w), dword_t'(avm_write));
            check_word("avm_read", dword_t'(s_r), dword_t'(avm_read));
        end
        if (acc_w) accept_write_beat();
        if (acc_r) accept_read_cmd();
        avm_waitrequest   = ($urandom_range(99, 0) < 30);
        avm_readdatavalid = 1'b0;
        if (rd_pending && rd_delay > 0) begin
            rd_delay--;
        end else if (rd_pending) begin
            avm_readdatavalid = 1'b1;
            avm_readdata      = slave_word(int'(rd_addr[11:2]) * 4);
            rd_addr++;
            rd_left--;
            rd_delay   = int'($urandom_range(1, 0));   // gaps between beats
            rd_pending = (rd_left > 0);
        end
    end

    //--------------------
    // CPU transactions
    task automatic run_write(input addr_t addr, input write_len_t len, input dword_t data);
        logic [7:0] be;
        logic [63:0] wide;
        int off;
        int base;
        off  = int'(addr[1:0]);
        base = int'(addr[11:2]) * 4;
        be   = '0;
        wide = '0;
        for (int i = 0; i < int'(len); i++) begin
            be[off + i]            = 1'b1;
            wide[(off + i)*8 +: 8] = data[i*8 +: 8];
        end
        exp_wr_addr  = addr[ADDR_W-1:2];
        exp_wr_count = (be[7:4] != 4'h0) ? 2'd2 : 2'd1;
        exp_be[0]    = be[3:0];
        exp_be[1]    = be[7:4];
        exp_wdata[0] = wide[31:0];
        exp_wdata[1] = wide[63:32];
        write_address = addr;
        write_length  = len;
        write_data    = data;
        write_do      = 1'b1;
        do begin
            @(negedge clk);
        end while (!write_done);
        write_do = 1'b0;
        for (int i = 0; i < int'(len); i++) begin
            ref_mem[int'(addr[11:0]) + i] = data[i*8 +: 8];
        end
        check_word("slave dword 0", ref_word(base), slave_word(base));
        check_word("slave dword 1", ref_word(base + 4), slave_word(base + 4));
        @(negedge clk);
    endtask

    task automatic run_read(input addr_t addr, input read_len_t len);
        read_data_t exp;
        int last;
        exp = '0;
        for (int i = 0; i < int'(len); i++) begin
            exp[i*8 +: 8] = ref_mem[int'(addr[11:0]) + i];
        end
        last         = int'(addr[1:0]) + int'(len) - 1;
        exp_rd_addr  = addr[ADDR_W-1:2];
        exp_rd_count = dword_len_t'(last / 4 + 1);
        read_address = addr;
        read_length  = len;
        read_do      = 1'b1;
        do begin
            @(negedge clk);
        end while (!read_done);
        read_do = 1'b0;
        check_read_data("read_data", exp, read_data);
        @(negedge clk);
    endtask

    //--------------------
    // watchdog
    initial begin
        repeat (N_TRANS * 64) @(posedge clk);
        report_failure("TIMEOUT: transactions stopped completing, the run hung");
    end

    //--------------------
    // test sequence
    initial begin
        int log_start;
        void'($urandom(9));
        read_do = 1'b0;
        write_do = 1'b0;
        read_address = '0;
        read_length = 4'd1;
        write_address = '0;
        write_length = 3'd1;
        write_data = '0;
        avm_waitrequest = 1'b0;
        avm_readdatavalid = 1'b0;
        avm_readdata = '0;
        wbeat = 0;
        rd_pending = 1'b0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            slave_mem[a] = fill_byte(a);
            ref_mem[a]   = fill_byte(a);
        end

        wait (!rst);
        repeat (4) begin                        // quiet after reset
            @(negedge clk);
            check_word("avm_read", 32'd0, dword_t'(avm_read));
            check_word("avm_write", 32'd0, dword_t'(avm_write));
            check_word("read_done", 32'd0, dword_t'(read_done));
            check_word("write_done", 32'd0, dword_t'(write_done));
        end

        repeat (N_WRITES) begin
            run_write(addr_t'($urandom_range(MEM_BYTES - 9, 0)),
                      write_len_t'($urandom_range(4, 1)), dword_t'($urandom));
        end
        repeat (N_READS) begin
            run_read(addr_t'($urandom_range(MEM_BYTES - 9, 0)),
                     read_len_t'($urandom_range(8, 1)));
        end

        // read and write together on disjoint halves of the window
        repeat (N_PAIRS) begin
            log_start = cmd_log.size();
            fork
                run_write(addr_t'($urandom_range(2039, 0)),
                          write_len_t'($urandom_range(4, 1)), dword_t'($urandom));
                run_read(addr_t'($urandom_range(MEM_BYTES - 9, 2048)),
                         read_len_t'($urandom_range(8, 1)));
            join
            if (cmd_log.size() <= log_start || cmd_log[log_start] != 1'b1) begin
                report_failure("write burst did not reach the bus before the read burst");
            end
        end

        for (int w = 0; w < MEM_BYTES / 4; w++) begin
            check_word("slave memory dword", ref_word(w * 4), slave_word(w * 4));
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- vlog.f
design/mem_pkg.sv
design/mem_link_if.sv
design/link_stage.sv
design/mem_read.sv
design/mem_write.sv
design/avalon_burst.sv
design/mem_top.sv
test/tb_clock.sv
test/tb_mem_top.sv
